// File: source/jpeg_quant_consts.svh
/* size constants of the quantizer: blocks per group, coefficients per block,
   buffer banks, coefficient and divisor widths, divider depth */

`ifndef JPEG_QUANT_CONSTS_SVH
`define JPEG_QUANT_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// group and block geometry

// blocks per group, one per DCT engine upstream
`define JQ_BLOCKS 5

// coefficients in one 8x8 block
`define JQ_COEFS 64

// coefficient buffer banks, so up to three groups can wait
`define JQ_BANKS 4

//////////////////////////////////////////////////////////////////////
// datapath widths

// signed coefficient, also the quotient width
`define JQ_COEF_WIDTH 16

// unsigned divisor from the quantization table
`define JQ_DIVISOR_WIDTH 8

// one restoring stage per quotient bit
`define JQ_DIV_STAGES 16

`endif

// File: source/jpeg_quant_pkg.sv
/* shared types of the quantizer: coefficient, buffer write, output tag
   and tagged quotient */

`include "jpeg_quant_consts.svh"

package jpeg_quant_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath words

    // signed DCT coefficient, reused for the quotient
    typedef logic signed [`JQ_COEF_WIDTH-1:0] coef_t;

    // one row-major write from the DCT side
    typedef struct packed {
        logic                          valid;
        logic [$clog2(`JQ_BLOCKS)-1:0] block;
        logic [$clog2(`JQ_COEFS)-1:0]  index;
        coef_t                         value;
    } coef_wr_t;

    //////////////////////////////////////////////////////////////////////
    // output stream

    // where a quotient belongs: block in the group, position in zig-zag order
    typedef struct packed {
        logic [$clog2(`JQ_BLOCKS)-1:0] block;
        logic [$clog2(`JQ_COEFS)-1:0]  zz_index;
    } quant_tag_t;

    // tagged quotient towards the entropy coder
    typedef struct packed {
        logic       valid;
        quant_tag_t tag;
        coef_t      quotient;
    } quant_out_t;

endpackage

// File: source/coef_buffer.sv
/* coefficient buffer: five block memories of four banks each, the write
   bank counter and the registered read mux */
`timescale 1ns/1ns
`include "jpeg_quant_consts.svh"

module coef_buffer
    import jpeg_quant_pkg::*;
(
    input  logic                          clock,
    input  logic                          nreset,
    input  coef_wr_t                      coef_wr_i,
    input  logic                          group_done_i,
    input  logic [$clog2(`JQ_BANKS)-1:0]  rd_bank_i,
    input  logic [$clog2(`JQ_BLOCKS)-1:0] rd_block_i,
    input  logic [$clog2(`JQ_COEFS)-1:0]  rd_index_i,
    output logic [$clog2(`JQ_BANKS)-1:0]  wr_bank_o,
    output coef_t                         rd_data_o
);

    localparam int BANK_BITS  = $clog2(`JQ_BANKS);
    localparam int BLOCK_BITS = $clog2(`JQ_BLOCKS);
    localparam int DEPTH      = `JQ_BANKS * `JQ_COEFS;
    localparam int ADDR_BITS  = $clog2(DEPTH);

    logic [BANK_BITS-1:0]            wr_bank_q;
    logic [ADDR_BITS-1:0]            wr_addr;
    logic [ADDR_BITS-1:0]            rd_addr;
    logic [BLOCK_BITS-1:0]           rd_block_q;
    coef_t [`JQ_BLOCKS-1:0]          blk_data;

    // a group closes with one pulse after its last write
    always_ff @(posedge clock) begin
        if (nreset) begin
            wr_bank_q <= '0;
        end else if (group_done_i) begin
            wr_bank_q <= wr_bank_q + BANK_BITS'(1);
        end
    end

    assign wr_bank_o = wr_bank_q;

    // bank selects the upper address bits, row-major index the lower ones
    assign wr_addr = {wr_bank_q, coef_wr_i.index};
    assign rd_addr = {rd_bank_i, rd_index_i};

    //////////////////////////////////////////////////////////////////////
    // one memory per block of the group

    for (genvar b = 0; b < `JQ_BLOCKS; b++) begin : g_block
        coef_t mem [DEPTH];
        coef_t rd_q;

        always_ff @(posedge clock) begin
            if (coef_wr_i.valid && (coef_wr_i.block == BLOCK_BITS'(b))) begin
                mem[wr_addr] <= coef_wr_i.value;
            end
            rd_q <= mem[rd_addr];
        end

        assign blk_data[b] = rd_q;
    end

    // remember which block was asked for, its data shows up next cycle
    always_ff @(posedge clock) begin
        rd_block_q <= rd_block_i;
    end

    always_comb begin
        rd_data_o = '0;
        for (int b = 0; b < `JQ_BLOCKS; b++) begin
            if (rd_block_q == BLOCK_BITS'(b)) begin
                rd_data_o = blk_data[b];
            end
        end
    end

endmodule

// File: source/quant_scheduler.sv
/* quantizer scheduler: group walk in zig-zag order, zig-zag to row-major
   table, quantization table ROM and the read-aligned divider inputs */
`timescale 1ns/1ns
`include "jpeg_quant_consts.svh"

module quant_scheduler
    import jpeg_quant_pkg::*;
(
    input  logic                          clock,
    input  logic                          nreset,
    input  logic [$clog2(`JQ_BANKS)-1:0]  wr_bank_i,
    output logic [$clog2(`JQ_BANKS)-1:0]  rd_bank_o,
    output logic [$clog2(`JQ_BLOCKS)-1:0] rd_block_o,
    output logic [$clog2(`JQ_COEFS)-1:0]  rd_index_o,
    output logic                          div_valid_o,
    output logic [`JQ_DIVISOR_WIDTH-1:0]  div_divisor_o,
    output quant_tag_t                    div_tag_o
);

    localparam int BANK_BITS  = $clog2(`JQ_BANKS);
    localparam int BLOCK_BITS = $clog2(`JQ_BLOCKS);
    localparam int INDEX_BITS = $clog2(`JQ_COEFS);

    // row-major position of each zig-zag index
    localparam logic [INDEX_BITS-1:0] ZZ_TO_RM [`JQ_COEFS] = '{
        6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
        6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
        6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
        6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
        6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
        6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
        6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
        6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
    };

    typedef enum logic {
        ST_WAIT,
        ST_QUANT
    } state_t;

    state_t                      state_q;
    logic [BANK_BITS-1:0]        rd_bank_q;
    logic [BANK_BITS-1:0]        next_bank;
    logic [BLOCK_BITS-1:0]       block_q;
    logic [INDEX_BITS-1:0]       zz_q;
    logic                        last_coef;
    logic                        last_block;
    logic                        issue;

    // divisors, stored in zig-zag order
    logic [`JQ_DIVISOR_WIDTH-1:0] qtable [`JQ_COEFS];

    initial begin
        $readmemh("quant_table.mem", qtable);
    end

    assign last_coef  = (zz_q == INDEX_BITS'(`JQ_COEFS - 1));
    assign last_block = (block_q == BLOCK_BITS'(`JQ_BLOCKS - 1));
    assign next_bank  = rd_bank_q + BANK_BITS'(1);
    assign issue      = (state_q == ST_QUANT);

    //////////////////////////////////////////////////////////////////////
    // group walk

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q   <= ST_WAIT;
            rd_bank_q <= '0;
            block_q   <= '0;
            zz_q      <= '0;
        end else begin
            case (state_q)
                ST_WAIT: begin
                    // a closed group sits in every bank behind the writer
                    if (rd_bank_q != wr_bank_i) begin
                        state_q <= ST_QUANT;
                    end
                end

                ST_QUANT: begin
                    // wraps to 0 after the last coefficient of a block
                    zz_q <= zz_q + INDEX_BITS'(1);
                    if (last_coef) begin
                        if (last_block) begin
                            block_q   <= '0;
                            rd_bank_q <= next_bank;
                            // next group already closed, keep going without a gap
                            if (next_bank == wr_bank_i) begin
                                state_q <= ST_WAIT;
                            end
                        end else begin
                            block_q <= block_q + BLOCK_BITS'(1);
                        end
                    end
                end

                default: begin
                    state_q <= ST_WAIT;
                end
            endcase
        end
    end

    assign rd_bank_o  = rd_bank_q;
    assign rd_block_o = block_q;
    assign rd_index_o = ZZ_TO_RM[zz_q];

    //////////////////////////////////////////////////////////////////////
    // divider inputs, one cycle behind the buffer address

    always_ff @(posedge clock) begin
        if (nreset) begin
            div_valid_o <= 1'b0;
        end else begin
            div_valid_o <= issue;
        end
    end

    always_ff @(posedge clock) begin
        div_divisor_o      <= qtable[zz_q];
        div_tag_o.block    <= block_q;
        div_tag_o.zz_index <= zz_q;
    end

endmodule

// File: source/pipelined_divider.sv
/* signed by unsigned restoring divider, one stage per quotient bit,
   with a tag of any packed type carried alongside */
`timescale 1ns/1ns
`include "jpeg_quant_consts.svh"

module pipelined_divider
    import jpeg_quant_pkg::*;
#(
    parameter type tag_t = logic [7:0]
) (
    input  logic                         clock,
    input  logic                         nreset,
    input  logic                         valid_i,
    input  coef_t                        dividend_i,
    input  logic [`JQ_DIVISOR_WIDTH-1:0] divisor_i,
    input  tag_t                         tag_i,
    output logic                         valid_o,
    output coef_t                        quotient_o,
    output tag_t                         tag_o
);

    localparam int CW     = `JQ_COEF_WIDTH;
    localparam int DW     = `JQ_DIVISOR_WIDTH;
    localparam int STAGES = `JQ_DIV_STAGES;

    // dq starts as the dividend magnitude, quotient bits shift in from the right
    typedef struct packed {
        logic          neg;
        logic [DW-1:0] divisor;
        logic [DW-1:0] rem;
        logic [CW-1:0] dq;
        tag_t          tag;
    } stage_t;

    stage_t              in_stage;
    stage_t              stage_q [STAGES];
    logic [STAGES-1:0]   valid_q;

    // one restoring step: bring down the next dividend bit, subtract if it fits
    function automatic stage_t restore_step(input stage_t s);
        logic [DW:0] trial;
        stage_t      r;
        r     = s;
        trial = {s.rem, s.dq[CW-1]};
        r.dq  = {s.dq[CW-2:0], 1'b0};
        if (trial >= {1'b0, s.divisor}) begin
            trial   = trial - {1'b0, s.divisor};
            r.dq[0] = 1'b1;
        end
        r.rem = trial[DW-1:0];
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // input stage

    // -32768 maps onto 16'h8000, which is its magnitude read as unsigned
    always_comb begin
        in_stage.neg     = dividend_i[CW-1];
        in_stage.divisor = divisor_i;
        in_stage.rem     = '0;
        in_stage.dq      = dividend_i[CW-1] ? -dividend_i : dividend_i;
        in_stage.tag     = tag_i;
    end

    //////////////////////////////////////////////////////////////////////
    // restoring stages and sign restore

    always_ff @(posedge clock) begin
        if (nreset) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], valid_i};
            valid_o <= valid_q[STAGES-1];
        end
    end

    always_ff @(posedge clock) begin
        stage_q[0] <= restore_step(in_stage);
        for (int k = 1; k < STAGES; k++) begin
            stage_q[k] <= restore_step(stage_q[k-1]);
        end
        // magnitude quotient, so the signed result truncates toward zero
        quotient_o <= stage_q[STAGES-1].neg ? coef_t'(-stage_q[STAGES-1].dq)
                                            : coef_t'(stage_q[STAGES-1].dq);
        tag_o      <= stage_q[STAGES-1].tag;
    end

endmodule

// File: source/jpeg_quantizer.sv
/* quantizer top level: coefficient buffer, zig-zag scheduler and the
   tagged divider */
`timescale 1ns/1ns
`include "jpeg_quant_consts.svh"

module jpeg_quantizer
    import jpeg_quant_pkg::*;
(
    input  logic       clock,
    input  logic       nreset,
    input  coef_wr_t   coef_wr_i,
    input  logic       group_done_i,
    output quant_out_t quant_o
);

    // buffer and scheduler
    logic [$clog2(`JQ_BANKS)-1:0]  wr_bank;
    logic [$clog2(`JQ_BANKS)-1:0]  rd_bank;
    logic [$clog2(`JQ_BLOCKS)-1:0] rd_block;
    logic [$clog2(`JQ_COEFS)-1:0]  rd_index;
    coef_t                         rd_data;

    // divider in and out
    logic                          div_valid;
    logic [`JQ_DIVISOR_WIDTH-1:0]  div_divisor;
    quant_tag_t                    div_tag;
    logic                          q_valid;
    coef_t                         q_quotient;
    quant_tag_t                    q_tag;

    coef_buffer i_coef_buffer (
        .clock        (clock),
        .nreset       (nreset),
        .coef_wr_i    (coef_wr_i),
        .group_done_i (group_done_i),
        .rd_bank_i    (rd_bank),
        .rd_block_i   (rd_block),
        .rd_index_i   (rd_index),
        .wr_bank_o    (wr_bank),
        .rd_data_o    (rd_data)
    );

    quant_scheduler i_quant_scheduler (
        .clock         (clock),
        .nreset        (nreset),
        .wr_bank_i     (wr_bank),
        .rd_bank_o     (rd_bank),
        .rd_block_o    (rd_block),
        .rd_index_o    (rd_index),
        .div_valid_o   (div_valid),
        .div_divisor_o (div_divisor),
        .div_tag_o     (div_tag)
    );

    // coefficient comes straight from the buffer, lined up with valid and tag
    pipelined_divider #(
        .tag_t (quant_tag_t)
    ) i_pipelined_divider (
        .clock      (clock),
        .nreset     (nreset),
        .valid_i    (div_valid),
        .dividend_i (rd_data),
        .divisor_i  (div_divisor),
        .tag_i      (div_tag),
        .valid_o    (q_valid),
        .quotient_o (q_quotient),
        .tag_o      (q_tag)
    );

    assign quant_o = '{valid: q_valid, tag: q_tag, quotient: q_quotient};

endmodule

// File: tb/clock_gen.sv
/* testbench clock source */
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock_o = ~clock_o;
        end
    end

endmodule

// File: tb/tb_jpeg_quantizer.sv
/* testbench of the quantizer: random group stimulus, reference model with
   its own zig-zag walk, compare tasks, output monitor and watchdog */
`timescale 1ns/1ns
`include "jpeg_quant_consts.svh"

module tb_jpeg_quantizer
    import jpeg_quant_pkg::*;
();

    localparam int BLOCK_BITS  = $clog2(`JQ_BLOCKS);
    localparam int INDEX_BITS  = $clog2(`JQ_COEFS);
    localparam int GROUP_COEFS = `JQ_BLOCKS * `JQ_COEFS;
    localparam int NUM_GROUPS  = 8;
    // each group is written, quantized and drained, plus reset and idle time
    localparam int WATCHDOG_CYCLES = NUM_GROUPS * GROUP_COEFS * 3 + 1000;
    localparam int unsigned SEED = 32'h0ce4_c1aa;

    logic       clock;
    logic       nreset;
    coef_wr_t   coef_wr;
    logic       group_done;
    quant_out_t quant_out;

    // reference model state
    logic [`JQ_DIVISOR_WIDTH-1:0] qtable [`JQ_COEFS];
    int         rm_of_zz [`JQ_COEFS];
    quant_out_t exp_q [$];
    int         cycle_cnt = 0;
    int         done_edge = 0;
    bit         latency_armed = 1'b0;
    bit         prev_valid = 1'b0;

    clock_gen #(.PERIOD_NS(8)) i_clock_gen (.clock_o(clock));

    jpeg_quantizer i_dut (
        .clock        (clock),
        .nreset       (nreset),
        .coef_wr_i    (coef_wr),
        .group_done_i (group_done),
        .quant_o      (quant_out)
    );

    //////////////////////////////////////////////////////////////////////
    // checks

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_quant(input quant_out_t got, input quant_out_t exp);
        if (got != exp) begin
            report_error($sformatf("got block %0d zz %0d quotient %0d, expected %0d %0d %0d",
                got.tag.block, got.tag.zz_index, got.quotient,
                exp.tag.block, exp.tag.zz_index, exp.quotient));
        end
    endtask

    task automatic check_idle(input quant_out_t got);
        if (got.valid) begin
            report_error($sformatf("unexpected output, block %0d zz %0d quotient %0d",
                got.tag.block, got.tag.zz_index, got.quotient));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("first output after %0d cycles, expected %0d", got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model

    // walk the anti-diagonals, even ones upward, odd ones downward
    task automatic build_zigzag();
        int n;
        int row;
        int col;
        n = 0;
        for (int s = 0; s < 15; s++) begin
            for (int k = 0; k < 8; k++) begin
                row = (s % 2 == 0) ? 7 - k : k;
                col = s - row;
                if (col >= 0 && col < 8) begin
                    rm_of_zz[n] = row * 8 + col;
                    n++;
                end
            end
        end
    endtask

    function automatic coef_t pick_edge();
        int unsigned sel;
        sel = $urandom_range(5);
        case (sel)
            0: return coef_t'(-32768);
            1: return coef_t'(32767);
            2: return '0;
            // every divisor is at least 10, so these give 0
            3: return coef_t'($urandom_range(9));
            4: return coef_t'(-int'($urandom_range(9, 1)));
            default: return coef_t'(-int'($urandom_range(32767, 1)));
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic drive_cycle(input coef_wr_t w, input logic done);
        @(negedge clock);
        coef_wr    = w;
        group_done = done;
    endtask

    // writes one group in random order, queues its quotients, then closes it
    task automatic write_group(input bit with_gaps, input bit edge_values);
        coef_t      vals [GROUP_COEFS];
        int         order [GROUP_COEFS];
        int         j;
        int         tmp;
        int         q;
        coef_wr_t   w;
        quant_out_t e;
        for (int n = 0; n < GROUP_COEFS; n++) begin
            vals[n]  = edge_values ? pick_edge() : coef_t'($urandom);
            order[n] = n;
        end
        for (int n = GROUP_COEFS - 1; n > 0; n--) begin
            j        = $urandom_range(n);
            tmp      = order[n];
            order[n] = order[j];
            order[j] = tmp;
        end
        for (int n = 0; n < GROUP_COEFS; n++) begin
            if (with_gaps && $urandom_range(3) == 0) begin
                drive_cycle('0, 1'b0);
            end
            w.valid = 1'b1;
            w.block = BLOCK_BITS'(order[n] / `JQ_COEFS);
            w.index = INDEX_BITS'(order[n] % `JQ_COEFS);
            w.value = vals[order[n]];
            drive_cycle(w, 1'b0);
        end
        // an idle design gives a fixed latency from the closing pulse
        latency_armed = (exp_q.size() == 0) && !quant_out.valid;
        for (int b = 0; b < `JQ_BLOCKS; b++) begin
            for (int z = 0; z < `JQ_COEFS; z++) begin
                // integer division truncates toward zero
                q = int'(vals[b * `JQ_COEFS + rm_of_zz[z]]) / int'(qtable[z]);
                e.valid        = 1'b1;
                e.tag.block    = BLOCK_BITS'(b);
                e.tag.zz_index = INDEX_BITS'(z);
                e.quotient     = coef_t'(q);
                exp_q.push_back(e);
            end
        end
        drive_cycle('0, 1'b1);
        done_edge = cycle_cnt + 1;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor, sampled on the falling edge

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(negedge clock) begin
        if (!nreset) begin
            if (exp_q.size() == 0) begin
                check_idle(quant_out);
            end else if (quant_out.valid) begin
                if (latency_armed) begin
                    check_latency(cycle_cnt - done_edge, `JQ_DIV_STAGES + 3);
                    latency_armed = 1'b0;
                end
                check_quant(quant_out, exp_q[0]);
                void'(exp_q.pop_front());
            end else if (prev_valid && exp_q[0].tag != '0) begin
                report_error("output stream stopped in the middle of a group");
            end
            prev_valid = quant_out.valid;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: the quantizer did not deliver all outputs within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        void'($urandom(SEED));
        nreset     = 1'b1;
        coef_wr    = '0;
        group_done = 1'b0;
        $readmemh("quant_table.mem", qtable);
        build_zigzag();
        repeat (8) @(posedge clock);
        @(negedge clock);
        nreset = 1'b0;
        repeat (20) drive_cycle('0, 1'b0);

        // one group with gaps on an idle design, also checks the latency
        write_group(1'b1, 1'b0);
        drive_cycle('0, 1'b0);
        wait_drained();

        // six groups back to back, bank pointers wrap
        for (int g = 0; g < 6; g++) begin
            write_group(1'b0, 1'b0);
        end
        drive_cycle('0, 1'b0);
        wait_drained();

        // extreme and small coefficients
        write_group(1'b1, 1'b1);
        // the whole group is out a fixed time after its closing pulse
        repeat (`JQ_DIV_STAGES + 3 + GROUP_COEFS + 40) drive_cycle('0, 1'b0);

        if (exp_q.size() != 0 || quant_out.valid) begin
            $display("model queue not empty at the end of the run");
            $display("TEST FAILED");
            $fatal(1, "leftover expected outputs");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: quant_table.mem
// divisors of the luminance quantization table in zig-zag order
// one hex byte per entry, 8 entries per line
10 0b 0c 0e 0c 0a 10 0e
0d 0e 12 11 10 13 18 28
1a 18 16 16 18 31 23 25
1d 28 3a 33 3d 3c 39 33
38 37 40 48 5c 4e 40 44
57 45 37 38 50 6d 51 57
5f 62 67 68 67 3e 4d 71
79 70 64 78 5c 65 67 63

// File: compile.f
+incdir+source
source/jpeg_quant_pkg.sv
source/coef_buffer.sv
source/quant_scheduler.sv
source/pipelined_divider.sv
source/jpeg_quantizer.sv
tb/clock_gen.sv
tb/tb_jpeg_quantizer.sv

// File: Makefile
TOP := tb_jpeg_quantizer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
